/* all.f */
hw/ciPkg.sv
hw/ciRequestIf.sv
hw/resetSequencer.sv
hw/ciDecoder.sv
hw/ciDataOps.sv
hw/profileCounters.sv
hw/ciResponse.sv
hw/customInstrTop.sv
test/ciTiming_chk.sv
test/tbCustomInstr.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run with Verilator, pass only when the pass line is printed
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tbCustomInstr -f all.f &&
  ./obj_dir/VtbCustomInstr +verilator+error+limit+100 | tee /dev/stderr | grep -qx "STATUS: PASS" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* test/tbCustomInstr.sv */
`timescale 1ns/1ps
`default_nettype none

module tbCustomInstr;
  import ciPkg::*;

  localparam int resetCycles    = 4;
  localparam int releaseCycles  = 16;
  localparam int swapTests      = 50;
  localparam int grayTests      = 25;  // First five are corner pixels
  localparam int unknownTests   = 24;
  localparam int profileCycles  = 40;
  localparam int drainCycles    = pipeDepth + 2;
  localparam int stimulusCycles = resetCycles + 8 + releaseCycles + swapTests + grayTests
                                  + unknownTests + profileCycles + 5 * drainCycles;
  localparam logic [ciNumberWidth-1:0] unusedNumber = 8'hA5;

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     ciStart;
  logic [ciNumberWidth-1:0] ciN;
  logic [dataWidth-1:0]     ciDataA;
  logic [dataWidth-1:0]     ciDataB;
  logic                     cpuStall;
  logic                     busIdle;
  logic                     ciDone;
  logic [dataWidth-1:0]     ciResult;
  logic                     peripheralResetN;

  int unsigned          cycleCount = 0;
  int unsigned          lastIssueEdge = 0;
  logic [31:0]          rngState = 32'h2734;
  int                   errorCount = 0;
  int                   testsFailed = 0;
  logic [dataWidth-1:0] expectValue [$];
  int unsigned          expectEdge [$];

  customInstrTop dut_i (.*);

  initial begin
    s_systemClock = 1'b0;
    forever #50 s_systemClock = ~s_systemClock;
  end

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= 2 * stimulusCycles) begin
      $display("Timeout after %0d cycles with %0d responses pending", cycleCount,
               expectValue.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] s;
    s = state ^ (state << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // Swap and grayscale results worked out from the instruction rules
  function automatic logic [dataWidth-1:0] expectedResult(input ciOpcode op,
      input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    logic [7:0] bytes [4];
    int red;
    int green;
    int blue;
    int gray;
    for (int i = 0; i < 4; i++) begin
      bytes[i] = a[8*i +: 8];
    end
    if (op == opSwap) begin
      if (b[0]) return {bytes[2], bytes[3], bytes[0], bytes[1]};
      return {bytes[0], bytes[1], bytes[2], bytes[3]};
    end
    red   = int'(a[15:11]);
    green = int'(a[10:5]);
    blue  = int'(a[4:0]);
    red   = red * 8 + red / 4;
    green = green * 4 + green / 16;
    blue  = blue * 8 + blue / 4;
    gray  = (54 * red + 183 * green + 19 * blue) / 256;
    return (gray / 8) * 2048 + (gray / 4) * 32 + gray / 8;
  endfunction

  function automatic logic [dataWidth-1:0] expectedCounter(input counterSel sel,
      input int window, input int accepted, input bit stallHeld, input bit idleHeld);
    case (sel)
      2'd0:    return window;
      2'd1:    return stallHeld ? window : 0;
      2'd2:    return idleHeld ? window : 0;
      default: return accepted;
    endcase
  endfunction

  // Outputs are settled by the falling edge
  always @(negedge s_systemClock) begin
    if (expectEdge.size() > 0 && expectEdge[0] + pipeDepth == cycleCount) begin
      if (ciDone !== 1'b1) begin
        $display("Missing ciDone at %0t for the start driven at edge %0d", $time, expectEdge[0]);
        errorCount++;
      end else if (ciResult !== expectValue[0]) begin
        $display("Mismatch at %0t: ciResult %h, expected %h", $time, ciResult, expectValue[0]);
        errorCount++;
      end
      void'(expectEdge.pop_front());
      void'(expectValue.pop_front());
    end else if (ciDone === 1'b1) begin
      $display("Unexpected ciDone at %0t with no start pending", $time);
      errorCount++;
    end else if (peripheralResetN === 1'b1 && ciResult !== '0) begin
      $display("Mismatch at %0t: ciResult %h while ciDone is low", $time, ciResult);
      errorCount++;
    end
  end

  task automatic issueInstr(input logic [ciNumberWidth-1:0] number,
      input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= number;
    ciDataA <= a;
    ciDataB <= b;
    lastIssueEdge = cycleCount + 1;  // Edge that drives this start
  endtask

  task automatic expectResponse(input logic [dataWidth-1:0] value);
    expectEdge.push_back(lastIssueEdge);
    expectValue.push_back(value);
  endtask

  task automatic issueData(input ciOpcode op, input logic [dataWidth-1:0] a,
      input logic [dataWidth-1:0] b);
    issueInstr(op == opSwap ? defaultSwapId : defaultGrayId, a, b);
    expectResponse(expectedResult(op, a, b));
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge s_systemClock);
      ciStart <= 1'b0;
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    idleCycles(drainCycles);
    if (expectValue.size() != 0) begin
      $display("Test %s left %0d responses that never arrived", name, expectValue.size());
      errorCount++;
      expectValue.delete();
      expectEdge.delete();
    end
    if (errorCount == errorsBefore) begin
      $display("Test %-8s passed", name);
    end else begin
      testsFailed++;
      $display("Test %-8s failed with %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  initial begin
    int          errorsBefore;
    int unsigned lockEdge;
    int unsigned startEdge;
    int          window;
    int          accepted;
    logic [dataWidth-1:0]     value;
    logic [ciNumberWidth-1:0] number;
    logic [15:0]              corners [5];
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    cpuStall    = 1'b0;
    busIdle     = 1'b0;
    corners     = '{16'h0000, 16'hFFFF, 16'hF800, 16'h07E0, 16'h001F};

    // Starts while the PLL is unlocked and while the counter runs are ignored
    errorsBefore = errorCount;
    for (int i = 0; i < resetCycles; i++) begin
      issueInstr(defaultSwapId, nextRandom(), nextRandom());
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    lockEdge = cycleCount + 1;
    for (int i = 0; i < 6; i++) begin
      issueInstr(defaultGrayId, nextRandom(), '0);
    end
    idleCycles(1);
    do begin
      @(negedge s_systemClock);
    end while (peripheralResetN !== 1'b1);
    if (cycleCount - lockEdge != releaseCycles) begin
      $display("Mismatch at %0t: reset released %0d cycles after lock, expected %0d", $time,
               cycleCount - lockEdge, releaseCycles);
      errorCount++;
    end
    finishTest("reset", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < swapTests; i++) begin
      value = nextRandom();
      issueData(opSwap, value, (nextRandom() & 32'hFFFF_FFFE) | 32'(i % 2));
    end
    finishTest("swap", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < grayTests; i++) begin
      value = nextRandom();
      if (i < 5) value[15:0] = corners[i];  // Upper half stays random
      issueData(opGray, value, nextRandom());
    end
    finishTest("gray", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < unknownTests; i++) begin
      if (i % 3 == 1) begin
        number = ciNumberWidth'(nextRandom());
        while (number == defaultSwapId || number == defaultGrayId || number == defaultProfileId)
          number++;
        issueInstr(number, nextRandom(), nextRandom());
      end else begin
        issueData((i % 2 == 1) ? opGray : opSwap, nextRandom(), nextRandom());
      end
    end
    finishTest("unknown", errorsBefore);

    errorsBefore = errorCount;
    @(posedge s_systemClock);
    cpuStall <= 1'b1;
    busIdle  <= 1'b0;
    issueInstr(defaultProfileId, '0, 32'h0000_0F0F);  // Clear and start all four
    expectResponse('0);
    startEdge = lastIssueEdge;
    accepted  = 0;
    for (int i = 0; i < 12; i++) begin
      if (i % 4 == 3) begin
        idleCycles(1);
      end else if (i % 4 == 1) begin
        issueInstr(unusedNumber, nextRandom(), nextRandom());
      end else begin
        issueData(opSwap, nextRandom(), nextRandom());
        accepted++;
      end
    end
    issueInstr(defaultProfileId, '0, 32'h0000_00F0);  // Stop all four
    window = lastIssueEdge - startEdge;
    expectResponse(window - 1);  // Stop edge not yet counted
    accepted++;
    idleCycles(4);
    repeat (2) begin
      for (int sel = 0; sel < 4; sel++) begin
        issueInstr(defaultProfileId, sel, '0);
        expectResponse(expectedCounter(counterSel'(sel), window, accepted, 1'b1, 1'b0));
      end
    end
    idleCycles(1);
    cpuStall <= 1'b0;
    finishTest("profile", errorsBefore);

    $display("Tests run 5, failed %0d, errors %0d, assertion failures %0d", testsFailed,
             errorCount, dut_i.timingChk_i.assertFailures);
    if (errorCount == 0 && dut_i.timingChk_i.assertFailures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/ciTiming_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ciTimingChk #(
  parameter logic [ciPkg::ciNumberWidth-1:0] swapId    = ciPkg::defaultSwapId,
  parameter logic [ciPkg::ciNumberWidth-1:0] grayId    = ciPkg::defaultGrayId,
  parameter logic [ciPkg::ciNumberWidth-1:0] profileId = ciPkg::defaultProfileId
) (
  input logic                            s_systemClock,
  input logic                            peripheralResetN,
  input logic                            ciStart,
  input logic [ciPkg::ciNumberWidth-1:0] ciN,
  input logic                            ciDone,
  input logic [ciPkg::dataWidth-1:0]     ciResult
);
  import ciPkg::*;

  int unsigned assertFailures = 0;
  logic        knownStart;

  assign knownStart = ciStart && (ciN == swapId || ciN == grayId || ciN == profileId);

  // No response while the core is held in reset
  doneQuietInReset: assert property (
    @(posedge s_systemClock) !peripheralResetN |-> ciDone !== 1'b1
  ) else begin
    $error("ciDone high while peripheralResetN is low");
    assertFailures++;
  end

  resultZeroWhenIdle: assert property (
    @(posedge s_systemClock) disable iff (!peripheralResetN) !ciDone |-> ciResult == '0
  ) else begin
    $error("ciResult not zero outside a done pulse");
    assertFailures++;
  end

  doneAfterPipe: assert property (
    @(posedge s_systemClock) peripheralResetN && knownStart |-> ##pipeDepth ciDone
  ) else begin
    $error("No ciDone %0d cycles after a known start", pipeDepth);
    assertFailures++;
  end

endmodule

bind customInstrTop ciTimingChk #(
  .swapId   (swapId),
  .grayId   (grayId),
  .profileId(profileId)
) timingChk_i (
  .s_systemClock   (s_systemClock),
  .peripheralResetN(peripheralResetN),
  .ciStart         (ciStart),
  .ciN             (ciN),
  .ciDone          (ciDone),
  .ciResult        (ciResult)
);

`default_nettype wire

/* hw/customInstrTop.sv */
`timescale 1ns/1ps
`default_nettype none

module customInstrTop #(
  parameter logic [ciPkg::ciNumberWidth-1:0] swapId    = ciPkg::defaultSwapId,
  parameter logic [ciPkg::ciNumberWidth-1:0] grayId    = ciPkg::defaultGrayId,
  parameter logic [ciPkg::ciNumberWidth-1:0] profileId = ciPkg::defaultProfileId,
  parameter int counterWidth     = ciPkg::defaultCounterWidth,
  parameter int resetCounterBits = ciPkg::defaultResetCounterBits
) (
  input  logic                            s_systemClock,
  input  logic                            s_pllLocked,
  input  logic                            ciStart,
  input  logic [ciPkg::ciNumberWidth-1:0] ciN,
  input  logic [ciPkg::dataWidth-1:0]     ciDataA,
  input  logic [ciPkg::dataWidth-1:0]     ciDataB,
  input  logic                            cpuStall,
  input  logic                            busIdle,
  output logic                            ciDone,
  output logic [ciPkg::dataWidth-1:0]     ciResult,
  output logic                            peripheralResetN
);
  import ciPkg::*;

  logic                 coreReset;
  logic                 opsDone;
  logic [dataWidth-1:0] opsResult;
  logic                 profDone;
  logic [dataWidth-1:0] profResult;

  ciRequestIf request_i ();

  resetSequencer #(.resetCounterBits(resetCounterBits)) resetSequencer_i (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .coreReset       (coreReset),
    .peripheralResetN(peripheralResetN)
  );

  ciDecoder #(
    .swapId   (swapId),
    .grayId   (grayId),
    .profileId(profileId)
  ) ciDecoder_i (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .request      (request_i.producer)
  );

  // Both units see every request and pick their own opcode
  ciDataOps ciDataOps_i (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .request      (request_i.consumer),
    .opsDone      (opsDone),
    .opsResult    (opsResult)
  );

  profileCounters #(.counterWidth(counterWidth)) profileCounters_i (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .request      (request_i.consumer),
    .cpuStall     (cpuStall),
    .busIdle      (busIdle),
    .profDone     (profDone),
    .profResult   (profResult)
  );

  ciResponse ciResponse_i (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .opsDone      (opsDone),
    .opsResult    (opsResult),
    .profDone     (profDone),
    .profResult   (profResult),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

endmodule

`default_nettype wire

/* hw/ciResponse.sv */
`timescale 1ns/1ps
`default_nettype none

module ciResponse (
  input  logic                        s_systemClock,
  input  logic                        coreReset,
  input  logic                        opsDone,
  input  logic [ciPkg::dataWidth-1:0] opsResult,
  input  logic                        profDone,
  input  logic [ciPkg::dataWidth-1:0] profResult,
  output logic                        ciDone,
  output logic [ciPkg::dataWidth-1:0] ciResult
);
  import ciPkg::*;

  logic                 mergedDone;
  logic [dataWidth-1:0] mergedResult;

  // Units hold their result at zero outside done
  assign mergedDone   = opsDone | profDone;
  assign mergedResult = opsResult | profResult;

  always_ff @(posedge s_systemClock) begin
    if (coreReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= mergedDone;
      ciResult <= mergedResult;
    end
  end

endmodule

`default_nettype wire

/* hw/profileCounters.sv */
`timescale 1ns/1ps
`default_nettype none

module profileCounters #(
  parameter int counterWidth = ciPkg::defaultCounterWidth
) (
  input  logic                        s_systemClock,
  input  logic                        coreReset,
  ciRequestIf.consumer                request,
  input  logic                        cpuStall,
  input  logic                        busIdle,
  output logic                        profDone,
  output logic [ciPkg::dataWidth-1:0] profResult
);
  import ciPkg::*;

  logic [counterWidth-1:0] counterValue [4];
  logic [3:0]              counterEnable;
  logic [3:0]              events;
  logic [3:0]              startMask;
  logic [3:0]              stopMask;
  logic [3:0]              clearMask;
  logic                    isProfile;
  counterSel               readSel;

  assign isProfile = request.valid && (request.opcode == opProfile);
  assign readSel   = request.dataA[1:0];

  // Cycles, stalls, idle bus, accepted instructions
  assign events = {request.valid, busIdle, cpuStall, 1'b1};

  always_comb begin
    startMask = '0;
    stopMask  = '0;
    clearMask = '0;
    if (isProfile) begin
      startMask = request.dataB[3:0];
      stopMask  = request.dataB[7:4];
      clearMask = request.dataB[11:8];
    end
  end

  // Enable seen at an edge still counts at the stop edge
  always_ff @(posedge s_systemClock) begin
    if (coreReset) begin
      counterEnable <= '0;
    end else begin
      counterEnable <= (counterEnable | startMask) & ~stopMask;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (coreReset) begin
      for (int i = 0; i < 4; i++) begin
        counterValue[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (clearMask[i]) begin
          counterValue[i] <= '0;  // Clear wins
        end else if (counterEnable[i] && events[i]) begin
          counterValue[i] <= counterValue[i] + 1'b1;
        end
      end
    end
  end

  // Read returns the value before this instruction's control
  always_ff @(posedge s_systemClock) begin
    if (coreReset) begin
      profDone   <= 1'b0;
      profResult <= '0;
    end else begin
      profDone   <= isProfile;
      profResult <= isProfile ? dataWidth'(counterValue[readSel]) : '0;
    end
  end

endmodule

`default_nettype wire

/* hw/ciDataOps.sv */
`timescale 1ns/1ps
`default_nettype none

module ciDataOps (
  input  logic                        s_systemClock,
  input  logic                        coreReset,
  ciRequestIf.consumer                request,
  output logic                        opsDone,
  output logic [ciPkg::dataWidth-1:0] opsResult
);
  import ciPkg::*;

  logic [dataWidth-1:0] swapValue;
  logic [dataWidth-1:0] grayValue;
  logic [7:0]           red8;
  logic [7:0]           green8;
  logic [7:0]           blue8;
  logic [15:0]          graySum;
  logic [7:0]           gray8;
  logic                 isSwap;
  logic                 isGray;

  assign isSwap = request.valid && (request.opcode == opSwap);
  assign isGray = request.valid && (request.opcode == opGray);

  // Bit 0 of B picks full reversal or half-word swap
  always_comb begin
    if (request.dataB[0]) begin
      swapValue = {request.dataA[23:16], request.dataA[31:24],
                   request.dataA[7:0], request.dataA[15:8]};
    end else begin
      swapValue = {request.dataA[7:0], request.dataA[15:8],
                   request.dataA[23:16], request.dataA[31:24]};
    end
  end

  // RGB565 widened to 8 bits per channel
  assign red8   = {request.dataA[15:11], request.dataA[15:13]};
  assign green8 = {request.dataA[10:5], request.dataA[10:9]};
  assign blue8  = {request.dataA[4:0], request.dataA[4:2]};

  // Weights sum to 256, so the sum fits 16 bits
  assign graySum = red8 * 16'd54 + green8 * 16'd183 + blue8 * 16'd19;
  assign gray8   = graySum[15:8];

  assign grayValue = {16'd0, gray8[7:3], gray8[7:2], gray8[7:3]};  // Back to RGB565

  always_ff @(posedge s_systemClock) begin
    if (coreReset) begin
      opsDone   <= 1'b0;
      opsResult <= '0;
    end else begin
      opsDone <= isSwap || isGray;
      if (isSwap) begin
        opsResult <= swapValue;
      end else if (isGray) begin
        opsResult <= grayValue;
      end else begin
        opsResult <= '0;  // Keeps the OR merge clean
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ciDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ciDecoder #(
  parameter logic [ciPkg::ciNumberWidth-1:0] swapId    = ciPkg::defaultSwapId,
  parameter logic [ciPkg::ciNumberWidth-1:0] grayId    = ciPkg::defaultGrayId,
  parameter logic [ciPkg::ciNumberWidth-1:0] profileId = ciPkg::defaultProfileId
) (
  input  logic                              s_systemClock,
  input  logic                              coreReset,
  input  logic                              ciStart,
  input  logic [ciPkg::ciNumberWidth-1:0]   ciN,
  input  logic [ciPkg::dataWidth-1:0]       ciDataA,
  input  logic [ciPkg::dataWidth-1:0]       ciDataB,
  ciRequestIf.producer                      request
);
  import ciPkg::*;

  ciOpcode decodedOp;

  always_comb begin
    decodedOp = opNone;
    if (ciN == swapId) begin
      decodedOp = opSwap;
    end else if (ciN == grayId) begin
      decodedOp = opGray;
    end else if (ciN == profileId) begin
      decodedOp = opProfile;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (coreReset) begin
      request.valid  <= 1'b0;
      request.opcode <= opNone;
    end else begin
      request.valid  <= ciStart && (decodedOp != opNone);  // Unknown numbers dropped here
      request.opcode <= decodedOp;
    end
  end

  // Operands only matter together with valid
  always_ff @(posedge s_systemClock) begin
    request.dataA <= ciDataA;
    request.dataB <= ciDataB;
  end

endmodule

`default_nettype wire

/* hw/resetSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module resetSequencer #(
  parameter int resetCounterBits = ciPkg::defaultResetCounterBits
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReset,
  output logic peripheralResetN
);

  logic [resetCounterBits-1:0] resetCount;
  logic                        released;

  assign released = resetCount[resetCounterBits-1];

  // Saturates once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!released) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign coreReset        = ~released;
  assign peripheralResetN = released;  // Camera side sees the same release

endmodule

`default_nettype wire

/* hw/ciRequestIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ciRequestIf;
  import ciPkg::*;

  logic                 valid;  // One cycle per accepted request
  ciOpcode              opcode;
  logic [dataWidth-1:0] dataA;
  logic [dataWidth-1:0] dataB;

  modport producer (
    output valid,
    output opcode,
    output dataA,
    output dataB
  );

  modport consumer (
    input valid,
    input opcode,
    input dataA,
    input dataB
  );

endinterface

`default_nettype wire

/* hw/ciPkg.sv */
`default_nettype none

package ciPkg;

  // Operand and result width of the custom-instruction port
  localparam int dataWidth     = 32;
  localparam int ciNumberWidth = 8;

  // Cycles from accepted start to done at the top level
  localparam int pipeDepth = 3;

  // Decoded operation
  typedef enum logic [1:0] {
    opNone,
    opSwap,
    opGray,
    opProfile
  } ciOpcode;

  // Index of a profiling counter
  typedef logic [1:0] counterSel;

  // Default custom-instruction numbers
  localparam logic [ciNumberWidth-1:0] defaultSwapId    = 8'd1;
  localparam logic [ciNumberWidth-1:0] defaultGrayId    = 8'd12;
  localparam logic [ciNumberWidth-1:0] defaultProfileId = 8'd8;

  // Profiling counter width and reset delay (2**(bits-1) cycles)
  localparam int defaultCounterWidth     = 32;
  localparam int defaultResetCounterBits = 5;

endpackage

`default_nettype wire
